// File: verilog/w2n_fifo_params.svh
//==================================================
// wide to narrow FIFO sizing
//==================================================

`ifndef W2N_FIFO_PARAMS_SVH
`define W2N_FIFO_PARAMS_SVH

//==================================================
// storage geometry
//==================================================

// word address bits
`define FIFO_ADDR_WIDTH 2

// words held in storage
`define FIFO_DEPTH (1 << `FIFO_ADDR_WIDTH)

//==================================================
// data widths
//==================================================

`define FIFO_IN_WIDTH 32
`define FIFO_OUT_WIDTH 8

// lanes per written word, and the lane index width
`define FIFO_LANES (`FIFO_IN_WIDTH / `FIFO_OUT_WIDTH)
`define FIFO_LANE_BITS 2

// highest lane count that still has room for a whole word
`define FIFO_FULL_LEVEL ((`FIFO_DEPTH - 1) * `FIFO_LANES)

`endif

// File: verilog/fifo_data_pkg.sv
//==================================================
// FIFO data types
//==================================================

`default_nettype none

`include "w2n_fifo_params.svh"

package fifo_data_pkg;

	// word as presented on the write side
	typedef logic [`FIFO_IN_WIDTH-1:0] wide_word_t;

	// one lane as returned on the read side
	typedef logic [`FIFO_OUT_WIDTH-1:0] lane_data_t;

endpackage

`default_nettype wire

// File: verilog/fifo_addr_pkg.sv
//==================================================
// FIFO address and count types
//==================================================

`default_nettype none

`include "w2n_fifo_params.svh"

package fifo_addr_pkg;

	// index of a word in storage
	typedef logic [`FIFO_ADDR_WIDTH-1:0] word_addr_t;

	// lane within a word, lane 0 is the low byte
	typedef logic [`FIFO_LANE_BITS-1:0] lane_sel_t;

	// stored lanes, 0 up to depth times lanes inclusive
	typedef logic [$clog2(`FIFO_DEPTH * `FIFO_LANES + 1)-1:0] level_t;

endpackage

`default_nettype wire

// File: verilog/fifo_word_store.sv
//==================================================
// FIFO word storage
//==================================================

`timescale 1ns/1ps
`default_nettype none

`include "w2n_fifo_params.svh"

module fifo_word_store
	import fifo_data_pkg::*;
	import fifo_addr_pkg::*;
(
	input  logic       clk,
	input  logic       rstn,
	input  logic       wr_en,
	input  wide_word_t data,
	input  word_addr_t rd_word,
	output wide_word_t rd_data
);

	//==================================================
	// storage and write pointer
	//==================================================

	wide_word_t mem [`FIFO_DEPTH];
	word_addr_t wr_ptr;

	// pointer width matches the depth, so it wraps by itself
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			wr_ptr <= '0;
		end
		else if (wr_en)
		begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// word lands at the current pointer
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_ptr] <= data;
		end
	end

	//==================================================
	// read port
	//==================================================

	// whole word back to the lane reader, no register
	assign rd_data = mem[rd_word];

endmodule

`default_nettype wire

// File: verilog/fifo_lane_reader.sv
//==================================================
// FIFO lane reader
//==================================================

`timescale 1ns/1ps
`default_nettype none

`include "w2n_fifo_params.svh"

module fifo_lane_reader
	import fifo_data_pkg::*;
	import fifo_addr_pkg::*;
(
	input  logic       clk,
	input  logic       rstn,
	input  logic       rd_en,
	input  wide_word_t rd_data,
	output word_addr_t rd_word,
	output lane_data_t q
);

	// low part of the read pointer
	lane_sel_t  rd_lane;
	lane_data_t lanes [`FIFO_LANES];

	// word index on top, lane index below, counted as one value
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			rd_word <= '0;
			rd_lane <= '0;
		end
		else if (rd_en)
		begin
			{rd_word, rd_lane} <= {rd_word, rd_lane} + 1'b1;
		end
	end

	// split the addressed word into lanes, lowest byte first
	for (genvar i = 0; i < `FIFO_LANES; i++)
	begin : g_lane
		assign lanes[i] = rd_data[i*`FIFO_OUT_WIDTH +: `FIFO_OUT_WIDTH];
	end

	// valid only while the FIFO holds data
	assign q = lanes[rd_lane];

endmodule

`default_nettype wire

// File: verilog/fifo_level_ctrl.sv
//==================================================
// FIFO occupancy and flags
//==================================================

`timescale 1ns/1ps
`default_nettype none

`include "w2n_fifo_params.svh"

module fifo_level_ctrl
	import fifo_addr_pkg::*;
(
	input  logic   clk,
	input  logic   rstn,
	input  logic   wr_req,
	input  logic   rd_req,
	output logic   wr_en,
	output logic   rd_en,
	output level_t level,
	output logic   empty,
	output logic   full
);

	// occupancy steps, in lanes
	localparam level_t word_step = level_t'(`FIFO_LANES);
	localparam level_t both_step = level_t'(`FIFO_LANES - 1);
	localparam level_t full_level = level_t'(`FIFO_FULL_LEVEL);

	//==================================================
	// request qualification
	//==================================================

	// a refused request leaves every register alone
	assign wr_en = wr_req && !full;
	assign rd_en = rd_req && !empty;

	//==================================================
	// occupancy register
	//==================================================

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			level <= '0;
		end
		else
		begin
			case ({wr_en, rd_en})
				2'b10:
				begin
					level <= level + word_step;
				end
				2'b01:
				begin
					level <= level - 1'b1;
				end
				// one word in, one lane out
				2'b11:
				begin
					level <= level + both_step;
				end
				default:
				begin
					level <= level;
				end
			endcase
		end
	end

	// flags decoded from the registered count
	assign empty = (level == '0);
	assign full = (level > full_level);

endmodule

`default_nettype wire

// File: verilog/w2n_fifo_top.sv
//==================================================
// wide to narrow synchronous FIFO
//==================================================

`timescale 1ns/1ps
`default_nettype none

module w2n_fifo_top
	import fifo_data_pkg::*;
	import fifo_addr_pkg::*;
(
	input  logic       clk,
	input  logic       rstn,
	input  logic       wr_req,
	input  wide_word_t data,
	input  logic       rd_req,
	output lane_data_t q,
	output level_t     level,
	output logic       empty,
	output logic       full
);

	// qualified strobes
	logic wr_en;
	logic rd_en;

	// read path between reader and store
	word_addr_t rd_word;
	wide_word_t rd_data;

	//==================================================
	// flags and occupancy
	//==================================================

	fifo_level_ctrl u_level_ctrl (
		.clk    (clk),
		.rstn   (rstn),
		.wr_req (wr_req),
		.rd_req (rd_req),
		.wr_en  (wr_en),
		.rd_en  (rd_en),
		.level  (level),
		.empty  (empty),
		.full   (full)
	);

	//==================================================
	// storage and lane selection
	//==================================================

	fifo_word_store u_word_store (
		.clk     (clk),
		.rstn    (rstn),
		.wr_en   (wr_en),
		.data    (data),
		.rd_word (rd_word),
		.rd_data (rd_data)
	);

	// q follows the read pointer combinationally
	fifo_lane_reader u_lane_reader (
		.clk     (clk),
		.rstn    (rstn),
		.rd_en   (rd_en),
		.rd_data (rd_data),
		.rd_word (rd_word),
		.q       (q)
	);

endmodule

`default_nettype wire

// File: verification/w2n_fifo_tb.sv
//==================================================
// wide to narrow FIFO testbench
//==================================================

`timescale 1ns/1ps
`default_nettype none

`include "w2n_fifo_params.svh"

module w2n_fifo_tb
	import fifo_data_pkg::*;
	import fifo_addr_pkg::*;
();

	localparam int clk_period = 40;
	localparam int reset_cycles = 10;
	localparam int directed_cycles = 200;
	localparam int phase_cycles = 100;
	localparam int random_cycles = 4 * phase_cycles;
	localparam int margin_cycles = 100;

	logic       clk;
	logic       rstn;
	logic       wr_req;
	logic       rd_req;
	wide_word_t data;
	lane_data_t q;
	level_t     level;
	logic       empty;
	logic       full;

	// reference model, one entry per stored lane
	lane_data_t  model_q [$];
	level_t      prev_count;
	logic        both_accepted;
	logic [31:0] rng_state;

	string test_name;
	int    test_errors;
	int    total_errors;
	int    tests_run;
	int    tests_failed;
	int    checks;

	w2n_fifo_top u_w2n_fifo_top (
		.clk    (clk),
		.rstn   (rstn),
		.wr_req (wr_req),
		.data   (data),
		.rd_req (rd_req),
		.q      (q),
		.level  (level),
		.empty  (empty),
		.full   (full)
	);

	always #(clk_period / 2) clk = ~clk;

	// watchdog sized from the test lengths
	initial
	begin
		#((reset_cycles + directed_cycles + random_cycles + margin_cycles) * clk_period);
		$display("timeout: the tests did not finish in time, stopped during %s", test_name);
		$display("Verification failed");
		$finish;
	end

	//==================================================
	// random numbers and reporting
	//==================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw(output logic [31:0] v);
		rng_state = xorshift32(rng_state);
		v = rng_state;
	endtask

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("** Error: %s: %s expected 0x%0h, actual 0x%0h",
			test_name, what, expected, actual);
		test_errors++;
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", test_name, what);
		test_errors++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		$display("%s: %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "FAILED",
			test_errors);
		total_errors += test_errors;
		tests_run++;
		if (test_errors > 0)
		begin
			tests_failed++;
		end
	endtask

	//==================================================
	// model and per cycle checks
	//==================================================

	// acceptance from the model's own count, inputs as sampled at the edge
	task automatic apply_model();
		logic w_ok;
		logic r_ok;
		int   i;
		w_ok = wr_req && (model_q.size() <= `FIFO_FULL_LEVEL);
		r_ok = rd_req && (model_q.size() > 0);
		prev_count = level_t'(model_q.size());
		both_accepted = w_ok && r_ok;
		if (r_ok)
		begin
			void'(model_q.pop_front());
		end
		if (w_ok)
		begin
			for (i = 0; i < `FIFO_LANES; i++)
			begin
				model_q.push_back(data[i*`FIFO_OUT_WIDTH +: `FIFO_OUT_WIDTH]);
			end
		end
	endtask

	task automatic check_outputs();
		level_t model_level;
		model_level = level_t'(model_q.size());
		checks += 3;
		assert (level == model_level)
		else
			report_mismatch("level", int'(model_level), int'(level));
		assert (empty == (model_q.size() == 0))
		else
			report_mismatch("empty", int'(model_q.size() == 0), int'(empty));
		assert (full == (model_q.size() > `FIFO_FULL_LEVEL))
		else
			report_mismatch("full", int'(model_q.size() > `FIFO_FULL_LEVEL), int'(full));
		// q is only defined while lanes are stored
		if (model_q.size() > 0)
		begin
			checks++;
			assert (q == model_q[0])
			else
				report_mismatch("q", int'(model_q[0]), int'(q));
		end
	endtask

	// one clock: model at the edge, new drive, check at the falling edge
	task automatic step(input logic w, input logic r, input wide_word_t d);
		@(posedge clk);
		apply_model();
		wr_req <= w;
		rd_req <= r;
		data <= d;
		@(negedge clk);
		check_outputs();
	endtask

	task automatic rand_step(input logic w, input logic r);
		logic [31:0] v;
		draw(v);
		step(w, r, v);
	endtask

	task automatic drain_fifo(input int limit);
		int n;
		n = 0;
		while (!empty && n < limit)
		begin
			rand_step(1'b0, 1'b1);
			n++;
		end
		if (!empty)
		begin
			report_failure("the FIFO did not go empty while draining");
		end
	endtask

	//==================================================
	// tests
	//==================================================

	task automatic check_after_reset();
		start_test("reset_state");
		checks += 3;
		assert (level == '0)
		else
			report_mismatch("level", 0, int'(level));
		assert (empty == 1'b1)
		else
			report_mismatch("empty", 1, int'(empty));
		assert (full == 1'b0)
		else
			report_mismatch("full", 0, int'(full));
		finish_test();
	endtask

	task automatic stream_words_in_order();
		start_test("lane_order");
		repeat (3) rand_step(1'b1, 1'b0);
		repeat (5) rand_step(1'b0, 1'b1);
		rand_step(1'b1, 1'b0);
		drain_fifo(40);
		finish_test();
	endtask

	task automatic overlap_write_and_read();
		int     hits;
		level_t expect_lvl;
		hits = 0;
		start_test("level_tracking");
		rand_step(1'b1, 1'b0);
		repeat (6)
		begin
			rand_step(1'b1, 1'b1);
			// a word in and a lane out in one edge
			if (both_accepted)
			begin
				hits++;
				expect_lvl = prev_count + level_t'(`FIFO_LANES - 1);
				checks++;
				assert (level == expect_lvl)
				else
					report_mismatch("level after write and read", int'(expect_lvl), int'(level));
			end
		end
		if (hits == 0)
		begin
			report_failure("no cycle accepted a write and a read together");
		end
		drain_fifo(40);
		finish_test();
	endtask

	task automatic fill_until_full();
		int     n;
		level_t held;
		start_test("full_block");
		n = 0;
		while (!full && n < 2 * `FIFO_DEPTH)
		begin
			rand_step(1'b1, 1'b0);
			n++;
		end
		if (!full)
		begin
			report_failure("full never went high while writing");
		end
		else if (int'(level) <= `FIFO_FULL_LEVEL)
		begin
			report_failure($sformatf("full rose at level %0d, not above %0d", level,
				`FIFO_FULL_LEVEL));
		end
		// lanes the model holds once writes stop being accepted
		held = level_t'(model_q.size());
		repeat (4)
		begin
			rand_step(1'b1, 1'b0);
			checks++;
			assert (level == held)
			else
				report_mismatch("level under write back-pressure", int'(held), int'(level));
		end
		finish_test();
	endtask

	task automatic drain_until_empty();
		logic [31:0] word;
		int          i;
		start_test("empty_block");
		// also reads back everything left from the full test
		drain_fifo(40);
		repeat (4)
		begin
			rand_step(1'b0, 1'b1);
			checks++;
			assert (level == '0)
			else
				report_mismatch("level under read back-pressure", 0, int'(level));
		end
		draw(word);
		step(1'b1, 1'b0, word);
		for (i = 0; i < `FIFO_LANES; i++)
		begin
			rand_step(1'b0, 1'b1);
			checks++;
			assert (q == word[i*`FIFO_OUT_WIDTH +: `FIFO_OUT_WIDTH])
			else
				report_mismatch($sformatf("lane %0d after refill", i),
					int'(word[i*`FIFO_OUT_WIDTH +: `FIFO_OUT_WIDTH]), int'(q));
		end
		rand_step(1'b0, 1'b0);
		if (!empty)
		begin
			report_failure("the FIFO is not empty after reading back the refill word");
		end
		finish_test();
	endtask

	// thresholds out of 256 for a write and a read request
	task automatic random_phase(input logic [7:0] wr_thresh, input logic [7:0] rd_thresh);
		logic [31:0] r;
		repeat (phase_cycles)
		begin
			draw(r);
			rand_step(r[7:0] < wr_thresh, r[15:8] < rd_thresh);
		end
	endtask

	task automatic random_traffic();
		start_test("random_mix");
		random_phase(8'd128, 8'd64);
		random_phase(8'd24, 8'd240);
		random_phase(8'd64, 8'd200);
		random_phase(8'd220, 8'd250);
		drain_fifo(40);
		finish_test();
	endtask

	//==================================================
	// main sequence
	//==================================================

	initial
	begin
		clk = 1'b0;
		rstn = 1'b0;
		wr_req = 1'b0;
		rd_req = 1'b0;
		data = '0;
		rng_state = 32'h591b;
		prev_count = '0;
		both_accepted = 1'b0;
		test_name = "reset";
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		checks = 0;
		repeat (reset_cycles) @(posedge clk);
		rstn <= 1'b1;
		@(negedge clk);
		check_after_reset();
		stream_words_in_order();
		overlap_write_and_read();
		fill_until_full();
		drain_until_empty();
		random_traffic();
		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, total_errors);
		if (total_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: w2n_fifo.f
// header directory
+incdir+verilog
// packages
verilog/fifo_data_pkg.sv
verilog/fifo_addr_pkg.sv
// design
verilog/fifo_word_store.sv
verilog/fifo_lane_reader.sv
verilog/fifo_level_ctrl.sv
verilog/w2n_fifo_top.sv
// testbench
verification/w2n_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the wide to narrow FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=w2n_fifo_tb
file_list=w2n_fifo.f
build_dir=build
obj_dir=$build_dir/obj_dir
build_log=$build_dir/build.log
sim_log=$build_dir/sim.log

if ! command -v verilator >/dev/null 2>&1
then
	echo "verilator not found in PATH"
	exit 1
fi

mkdir -p "$build_dir"
status=$?
if [ $status -ne 0 ]
then
	echo "could not create $build_dir"
	exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module "$top" -f "$file_list" \
	-Mdir "$obj_dir" -o "$top" > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]
then
	cat "$build_log"
	echo "build failed with status $status"
	exit 1
fi

"$obj_dir/$top" > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]
then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$sim_log"
then
	exit 1
fi

if ! grep -q "Verification passed" "$sim_log"
then
	echo "simulation log is incomplete"
	exit 1
fi

exit 0
